// ==== hw/lsuPkg.sv ====
// shared widths, data region, memRw codes and funct3 view; import into every lsu block and the testbench
`default_nettype none

package lsuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath and bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int Xlen   = 64;    // hart register width
  localparam int PaBits = 32;    // physical bus address width

  // single legal data region, identity mapped
  localparam logic [PaBits-1:0] DataBase  = 32'h8000_0000;
  localparam int                DataBytes = 4096;

  // memRw encodings, read in bit 1 and write in bit 0
  localparam logic [1:0] MemRead  = 2'b10;
  localparam logic [1:0] MemWrite = 2'b01;

  // access size codes from funct3[1:0]
  localparam logic [1:0] SizeByte   = 2'd0;   // lb lbu sb
  localparam logic [1:0] SizeHalf   = 2'd1;   // lh lhu sh
  localparam logic [1:0] SizeWord   = 2'd2;   // lw lwu sw
  localparam logic [1:0] SizeDouble = 2'd3;   // ld sd

  ////////////////////////////////////////////////////////////////////////////
  // funct3 seen as opcode field or as sign/size fields
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       isUnsigned;   // bit 2, zero extend on load
    logic [1:0] size;         // bits 1:0, log2 of byte count
  } funct3Fields;

  typedef union packed {
    logic [2:0]  raw;         // as carried in the instruction word
    funct3Fields f;           // as the lsu decodes it
  } funct3U;

endpackage

`default_nettype wire

// ==== hw/lsuDecode.sv ====
// decode stage of the lsu, turns a memory-stage request into size, sign, faults and a bus go
`default_nettype none

module lsuDecode import lsuPkg::*; (
  input  logic [1:0]      memRw,                // read in bit 1, write in bit 0
  input  funct3U          funct3,
  input  logic [Xlen-1:0] memAdr,
  output logic            isLoad,
  output logic            isStore,
  output logic            accessGo,             // legal access, start bus cycle
  output logic            isUnsignedM,
  output logic [1:0]      sizeM,
  output logic            loadMisalignedFault,
  output logic            storeMisalignedFault,
  output logic            loadAccessFault,
  output logic            storeAccessFault
);

  logic misaligned;    // address not a multiple of the access size
  logic outOfRange;    // address outside the data region

  // both-bits-set is never issued, so exact compares are enough
  assign isLoad  = (memRw == MemRead);
  assign isStore = (memRw == MemWrite);

  assign sizeM       = funct3.f.size;
  assign isUnsignedM = funct3.f.isUnsigned;

  // natural alignment check per access size
  always_comb begin
    case (sizeM)
      SizeByte:   misaligned = 1'b0;
      SizeHalf:   misaligned = memAdr[0];
      SizeWord:   misaligned = |memAdr[1:0];
      default:    misaligned = |memAdr[2:0];    // doubleword
    endcase
  end

  // region bounds widened to the full address, upper bits must be zero
  assign outOfRange = (memAdr < Xlen'(DataBase))
                    | (memAdr >= Xlen'(DataBase) + Xlen'(DataBytes));

  // misaligned wins over access fault
  assign loadMisalignedFault  = isLoad & misaligned;
  assign storeMisalignedFault = isStore & misaligned;
  assign loadAccessFault      = isLoad & ~misaligned & outOfRange;
  assign storeAccessFault     = isStore & ~misaligned & outOfRange;

  assign accessGo = (isLoad | isStore) & ~misaligned & ~outOfRange;

endmodule

`default_nettype wire

// ==== hw/lsuBusFsm.sv ====
// execute stage bus FSM of the lsu, holds the read or write strobe and stalls the pipeline until ack
`default_nettype none

module lsuBusFsm (
  input  logic clk,
  input  logic rst,
  input  logic accessGo,    // legal request from decode
  input  logic isLoad,      // held stable by the pipeline while stalled
  input  logic isStore,
  input  logic busAck,      // one-cycle pulse from memory
  output logic busRead,
  output logic busWrite,
  output logic lsuStall
);

  ////////////////////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    Ready,     // idle, request decoded combinationally
    Access     // strobe out, waiting for ack
  } stateT;

  stateT state;
  stateT nextState;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= Ready;
    end else begin
      state <= nextState;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // next state and stall
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    lsuStall  = 1'b0;
    case (state)
      Ready: begin
        // stall in the request cycle itself so the pipeline holds its inputs
        lsuStall = accessGo;
        if (accessGo) begin
          nextState = Access;
        end
      end
      Access: begin
        lsuStall = ~busAck;                 // retire at the edge ending the ack cycle
        if (busAck) begin
          nextState = Ready;                // strobe drops next cycle
        end
      end
      default: begin
        nextState = Ready;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus strobes
  ////////////////////////////////////////////////////////////////////////////

  // request kind does not move during Access, so decode straight off the state
  assign busRead  = (state == Access) & isLoad;
  assign busWrite = (state == Access) & isStore;

endmodule

`default_nettype wire

// ==== hw/lsuStoreAlign.sv ====
// store side of the lsu result stage, puts write data on its byte lanes and builds the byte enable
`default_nettype none

module lsuStoreAlign import lsuPkg::*; (
  input  logic [1:0]      sizeM,
  input  logic [2:0]      memAdr,         // byte offset in the bus word
  input  logic [Xlen-1:0] writeData,
  output logic [7:0]      busByteEn,
  output logic [Xlen-1:0] busWriteData
);

  // replicate the low bytes so every lane the offset can pick carries them
  always_comb begin
    case (sizeM)
      SizeByte:   busWriteData = {8{writeData[7:0]}};
      SizeHalf:   busWriteData = {4{writeData[15:0]}};
      SizeWord:   busWriteData = {2{writeData[31:0]}};
      default:    busWriteData = writeData;
    endcase
  end

  // enable mask shifted up to the addressed lane, alignment already checked
  always_comb begin
    case (sizeM)
      SizeByte:   busByteEn = 8'b0000_0001 << memAdr;
      SizeHalf:   busByteEn = 8'b0000_0011 << memAdr;
      SizeWord:   busByteEn = 8'b0000_1111 << memAdr;
      default:    busByteEn = 8'b1111_1111;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/lsuLoadAlign.sv ====
// load side of the lsu result stage, extracts and extends the addressed bytes into readDataW
`default_nettype none

module lsuLoadAlign import lsuPkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            busAck,
  input  logic            isLoad,
  input  logic [1:0]      sizeM,
  input  logic            isUnsignedM,
  input  logic [2:0]      memAdr,         // byte offset in the bus word
  input  logic [Xlen-1:0] busReadData,    // valid in the ack cycle only
  output logic [Xlen-1:0] readDataW
);

  logic [Xlen-1:0] shifted;      // addressed bytes moved to lane 0
  logic [Xlen-1:0] loadValue;    // extended result
  logic            signBit;

  assign shifted = busReadData >> {memAdr, 3'b000};

  // top bit of the loaded item, masked for unsigned forms
  always_comb begin
    case (sizeM)
      SizeByte:   signBit = shifted[7];
      SizeHalf:   signBit = shifted[15];
      SizeWord:   signBit = shifted[31];
      default:    signBit = shifted[63];
    endcase
    signBit = signBit & ~isUnsignedM;
  end

  always_comb begin
    case (sizeM)
      SizeByte:   loadValue = {{56{signBit}}, shifted[7:0]};
      SizeHalf:   loadValue = {{48{signBit}}, shifted[15:0]};
      SizeWord:   loadValue = {{32{signBit}}, shifted[31:0]};
      default:    loadValue = shifted;        // ld, no extension
    endcase
  end

  // write-back register, only a read ack updates it
  always_ff @(posedge clk) begin
    if (rst) begin
      readDataW <= '0;
    end else if (busAck & isLoad) begin
      readDataW <= loadValue;
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsu.sv ====
// top of the memory-stage load/store unit, ties pipeline request ports to the single data bus
`default_nettype none

module lsu import lsuPkg::*; (
  input  logic              clk,
  input  logic              rst,
  // pipeline request, held while lsuStall is high
  input  logic [1:0]        memRw,
  input  funct3U            funct3,
  input  logic [Xlen-1:0]   memAdr,
  input  logic [Xlen-1:0]   writeData,
  output logic              lsuStall,
  output logic [Xlen-1:0]   readDataW,
  // faults to the trap logic
  output logic              loadMisalignedFault,
  output logic              storeMisalignedFault,
  output logic              loadAccessFault,
  output logic              storeAccessFault,
  // data bus
  output logic [PaBits-1:0] busAdr,
  output logic              busRead,
  output logic              busWrite,
  output logic [7:0]        busByteEn,
  output logic [Xlen-1:0]   busWriteData,
  input  logic              busAck,
  input  logic [Xlen-1:0]   busReadData
);

  logic       isLoad;
  logic       isStore;
  logic       accessGo;
  logic       isUnsignedM;
  logic [1:0] sizeM;

  ////////////////////////////////////////////////////////////////////////////
  // decode, bus control, lane steering
  ////////////////////////////////////////////////////////////////////////////

  lsuDecode decode (
    .memRw(memRw), .funct3(funct3), .memAdr(memAdr),
    .isLoad(isLoad), .isStore(isStore), .accessGo(accessGo),
    .isUnsignedM(isUnsignedM), .sizeM(sizeM),
    .loadMisalignedFault(loadMisalignedFault),
    .storeMisalignedFault(storeMisalignedFault),
    .loadAccessFault(loadAccessFault),
    .storeAccessFault(storeAccessFault)
  );

  lsuBusFsm busFsm (
    .clk(clk), .rst(rst), .accessGo(accessGo),
    .isLoad(isLoad), .isStore(isStore), .busAck(busAck),
    .busRead(busRead), .busWrite(busWrite), .lsuStall(lsuStall)
  );

  lsuStoreAlign storeAlign (
    .sizeM(sizeM), .memAdr(memAdr[2:0]), .writeData(writeData),
    .busByteEn(busByteEn), .busWriteData(busWriteData)
  );

  lsuLoadAlign loadAlign (
    .clk(clk), .rst(rst), .busAck(busAck), .isLoad(isLoad),
    .sizeM(sizeM), .isUnsignedM(isUnsignedM), .memAdr(memAdr[2:0]),
    .busReadData(busReadData), .readDataW(readDataW)
  );

  // identity translation, word aligned on the bus
  assign busAdr = {memAdr[PaBits-1:3], 3'b000};

endmodule

`default_nettype wire

// ==== verification/lsuBus_sva.sv ====
// bus strobe rules of the lsu FSM, bound into every lsuBusFsm instance
`default_nettype none

module lsuBusSva (
  input logic clk,
  input logic rst,
  input logic busRead,
  input logic busWrite,
  input logic busAck
);
  timeunit 1ns;
  timeprecision 1ps;

  // read and write never together
  assert property (@(posedge clk) disable iff (rst) !(busRead && busWrite))
    else $error("read and write strobes high together");

  // strobe held until ack
  assert property (@(posedge clk) disable iff (rst) (busRead && !busAck) |=> busRead)
    else $error("read strobe dropped before ack");
  assert property (@(posedge clk) disable iff (rst) (busWrite && !busAck) |=> busWrite)
    else $error("write strobe dropped before ack");

  // strobe falls right after ack
  assert property (@(posedge clk) disable iff (rst) ((busRead || busWrite) && busAck)
                   |=> !(busRead || busWrite))
    else $error("strobe still high after ack");

  assert property (@(posedge clk) rst |=> !(busRead || busWrite))
    else $error("strobe high after reset");

endmodule

bind lsuBusFsm lsuBusSva busSva (
  .clk(clk), .rst(rst), .busRead(busRead), .busWrite(busWrite), .busAck(busAck)
);

`default_nettype wire

// ==== verification/lsuTb.sv ====
// testbench for the lsu top, drives LCG-random requests against a bus memory model and a byte model
`default_nettype none

module lsuTb import lsuPkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RstCycles = 5;
  localparam int NumLoads  = 40;
  localparam int NumPairs  = 30;    // store followed by reload
  localparam int NumBad    = 20;    // per fault kind
  localparam int NumOps    = NumLoads + 2 * NumPairs + 2 * NumBad;
  localparam int OpCycles  = 6;     // budget per op, slow acks offset by two-cycle faults

  logic clk = 1'b0;
  logic rst;
  logic [1:0] memRw;
  funct3U funct3;
  logic [Xlen-1:0] memAdr, writeData, readDataW, busWriteData, busReadData;
  logic lsuStall, loadMisalignedFault, storeMisalignedFault, loadAccessFault, storeAccessFault;
  logic [PaBits-1:0] busAdr;
  logic busRead, busWrite, busAck;
  logic [7:0] busByteEn;

  logic [31:0] lcgState = 32'd19;
  logic [63:0] mem [logic [31:0]];   // bus memory, keyed by word address
  logic [7:0] refMem [DataBytes];    // reference byte image of the region
  logic [Xlen-1:0] expRead;          // readDataW the model expects
  int ackDelay;

  lsu uut (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // top bit of the next LCG value, the best mixed one
  function automatic logic randBit();
    logic [31:0] r;
    r = lcgNext();
    return r[31];
  endfunction

  // every bit of the byte offset folds into the pattern
  function automatic logic [7:0] fillByte(int unsigned ofs);
    return 8'(ofs) ^ 8'(ofs >> 4) ^ 8'(ofs >> 8) ^ 8'h5A;
  endfunction

  function automatic logic [Xlen-1:0] expectLoad(logic [Xlen-1:0] adr, funct3U f);
    logic [Xlen-1:0] v;
    int n;
    v = '0;
    n = 1 << f.f.size;
    for (int i = 0; i < n; i++) v[8*i +: 8] = refMem[int'(adr - DataBase) + i];
    if (!f.f.isUnsigned && n < 8 && v[8*n-1]) v = v | ({Xlen{1'b1}} << (8 * n));
    return v;
  endfunction

  task automatic stopRun();
    $display("** FAIL **");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkData(string name, logic [Xlen-1:0] exp, logic [Xlen-1:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      stopRun();
    end
  endtask

  task automatic checkFaults(string name, logic [3:0] exp, logic [3:0] act);
    if (exp !== act) begin
      $display("ERR %s faults expected %b actual %b", name, exp, act);
      stopRun();
    end
  endtask

  task automatic checkFunct3(string name, funct3U exp, funct3U act);
    if (exp !== act) begin
      $display("ERR %s funct3 expected %b actual %b", name, exp.raw, act.raw);
      stopRun();
    end
  endtask

  task automatic checkByteEn(string name, logic [7:0] exp, logic [7:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stopRun();
    end
  endtask

  task automatic checkFlag(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      stopRun();
    end
  endtask

  // bus memory, ack after 0 to 3 wait cycles once the strobe is seen
  always @(posedge clk) begin
    busAck <= 1'b0;
    if (rst) begin
      ackDelay <= 0;
    end else if ((busRead | busWrite) && !busAck) begin
      if (ackDelay == 0) begin
        busAck <= 1'b1;
        ackDelay <= int'(lcgNext() >> 28) % 4;
        if (busRead) busReadData <= mem[busAdr];
        for (int i = 0; i < 8; i++) begin
          if (busWrite && busByteEn[i]) mem[busAdr][8*i +: 8] <= busWriteData[8*i +: 8];
        end
      end else begin
        ackDelay <= ackDelay - 1;
      end
    end
  end

  task automatic doOp(string name, logic [1:0] rw, funct3U f, logic [Xlen-1:0] adr,
                      logic [Xlen-1:0] wd);
    logic mis, oor, ld, st;
    logic [7:0] expEn;
    ld  = (rw == MemRead);
    st  = (rw == MemWrite);
    mis = (adr % (1 << f.f.size)) != 0;
    oor = (adr < DataBase) || (adr >= DataBase + DataBytes);
    expEn = '0;                              // one lane per stored byte from the offset up
    for (int i = 0; i < (1 << f.f.size) && !mis; i++) begin
      expEn[adr[2:0] + i] = 1'b1;
    end
    @(posedge clk);
    memRw <= rw;
    funct3 <= f;
    memAdr <= adr;
    writeData <= wd;
    @(negedge clk);
    checkFaults(name, {ld & mis, st & mis, ld & !mis & oor, st & !mis & oor},
                {loadMisalignedFault, storeMisalignedFault, loadAccessFault, storeAccessFault});
    checkFunct3(name, f, funct3U'({uut.isUnsignedM, uut.sizeM}));
    if (mis || oor) begin
      checkFlag({name, " stall on fault"}, 1'b0, lsuStall);
    end else begin
      checkFlag({name, " stall in request cycle"}, 1'b1, lsuStall);
      do begin
        @(negedge clk);
        checkFlag({name, " strobe"}, 1'b1, ld ? busRead : busWrite);
        checkFlag({name, " stall until ack"}, ~busAck, lsuStall);
        if (st) checkByteEn({name, " byte enable"}, expEn, busByteEn);
      end while (lsuStall);
      if (ld) expRead = expectLoad(adr, f);
      for (int i = 0; i < 8 && st; i++) begin
        if (i < (1 << f.f.size)) refMem[int'(adr - DataBase) + i] = wd[8*i +: 8];
      end
    end
    @(posedge clk);
    memRw <= 2'b00;    // retire edge, go idle
    @(negedge clk);
    checkFlag({name, " strobe after retire"}, 1'b0, busRead | busWrite);
    checkData(name, expRead, readDataW);
  endtask

  function automatic logic [Xlen-1:0] inRegion(logic [1:0] size);
    return Xlen'(DataBase) + ((lcgNext() >> 16) & 32'hFFF & ~((32'd1 << size) - 1));
  endfunction

  // watchdog sized from the op count
  initial begin
    #(RstCycles * 10 + NumOps * OpCycles * 10);
    $display("timeout, the DUT never finished the request sequence");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  initial begin
    funct3U f;
    logic [Xlen-1:0] adr, wd;
    rst = 1'b1;
    memRw = 2'b00;
    funct3 = '0;
    memAdr = '0;
    writeData = '0;
    expRead = '0;
    busAck = 1'b0;
    busReadData = '0;
    for (int i = 0; i < DataBytes; i++) refMem[i] = fillByte(i);
    for (int w = 0; w < DataBytes / 8; w++) begin
      for (int b = 0; b < 8; b++) mem[DataBase + 8 * w][8*b +: 8] = fillByte(8 * w + b);
    end
    // reset
    repeat (RstCycles) begin
      @(negedge clk);
      checkFlag("reset strobes", 1'b0, busRead | busWrite | lsuStall);
      checkData("reset readDataW", '0, readDataW);
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkFlag("after reset strobes", 1'b0, busRead | busWrite | lsuStall);
    checkData("after reset readDataW", '0, readDataW);
    // aligned loads of every size and sign
    for (int i = 0; i < NumLoads; i++) begin
      f.raw = 3'(lcgNext() >> 20);
      if (f.raw == 3'b111) f.raw = 3'b011;    // no ldu in rv64
      doOp("aligned load", MemRead, f, inRegion(f.f.size), '0);
    end
    // stores then reloads through the same address
    for (int i = 0; i < NumPairs; i++) begin
      f.raw = {1'b0, 2'(lcgNext() >> 24)};
      adr = inRegion(f.f.size);
      wd = {lcgNext(), lcgNext()};
      doOp("store", MemWrite, f, adr, wd);
      f.f.isUnsigned = (f.f.size != SizeDouble) & randBit();
      doOp("reload", MemRead, f, adr, '0);
    end
    // misaligned, odd address is bad for every size above byte
    for (int i = 0; i < NumBad; i++) begin
      f.raw = {1'b0, 2'(1 + (lcgNext() >> 30) % 3)};
      doOp("misaligned", randBit() ? MemRead : MemWrite, f, inRegion(f.f.size) | 1, '1);
    end
    // aligned but outside the region, below or above
    for (int i = 0; i < NumBad; i++) begin
      f.raw = {1'b0, 2'(lcgNext() >> 24)};
      adr = randBit() ? Xlen'(DataBase) - 8 * (1 + (lcgNext() >> 24))
                      : Xlen'(DataBase) + DataBytes + 8 * (lcgNext() >> 24);
      doOp("out of range", randBit() ? MemRead : MemWrite, f, adr, '1);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/lsuPkg.sv
hw/lsuDecode.sv
hw/lsuBusFsm.sv
hw/lsuStoreAlign.sv
hw/lsuLoadAlign.sv
hw/lsu.sv
verification/lsuBus_sva.sv
verification/lsuTb.sv
